// ==== hw/renameStage_config.svh ====
`ifndef RENAME_STAGE_CONFIG_SVH
`define RENAME_STAGE_CONFIG_SVH

// ********************
// rename stage sizing
// ********************

// reorder buffer entries.
// also sets the width of a ROB tag.
`define RENAME_ROB_DEPTH 8

// architectural registers, one alias slot each.
`define RENAME_REG_COUNT 16

// operand and result width in bits.
`define RENAME_DATA_W 32

`endif // RENAME_STAGE_CONFIG_SVH

// ==== hw/renamePkg.sv ====
`include "renameStage_config.svh"

package renamePkg;

  // ********************
  // index types
  // ********************

  // ROB entry index.
  typedef logic [$clog2(`RENAME_ROB_DEPTH)-1:0] robTagT;

  // architectural register index.
  typedef logic [$clog2(`RENAME_REG_COUNT)-1:0] archRegT;

  // ********************
  // payload types
  // ********************

  // operand or result value.
  // the same width on the CDB, commit and operand paths.
  typedef logic [`RENAME_DATA_W-1:0] dataT;

endpackage

// ==== hw/robValueBuffer.sv ====
`timescale 1ns/1ps
`include "renameStage_config.svh"

module robValueBuffer import renamePkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   cdbValid,    // result broadcast.
  input  robTagT cdbTag,
  input  dataT   cdbValue,
  input  logic   commitValid, // retiring entry.
  input  robTagT commitTag,
  input  logic   flush,
  input  robTagT rd1Tag,      // lookup tags, one per source.
  input  robTagT rd2Tag,
  output logic   rd1Ready,
  output dataT   rd1Value,
  output logic   rd2Ready,
  output dataT   rd2Value
);

  // ********************
  // storage
  // ********************
  dataT                         resultMem [`RENAME_ROB_DEPTH]; // broadcast results.
  logic [`RENAME_ROB_DEPTH-1:0] readyBits;                     // result present.

  // ready bit as it stands after this edge.
  function automatic logic fwdReady(robTagT tag);
    logic rdy;
    rdy = readyBits[tag];
    if (cdbValid && cdbTag == tag)
      rdy = 1'b1;                         // broadcast lands now.
    if (commitValid && commitTag == tag)
      rdy = 1'b0;                         // commit beats broadcast.
    if (flush)
      rdy = 1'b0;
    return rdy;
  endfunction

  // value as it stands after this edge.
  function automatic dataT fwdValue(robTagT tag);
    dataT val;
    val = resultMem[tag];
    if (cdbValid && !flush && cdbTag == tag)
      val = cdbValue;                     // same-edge broadcast.
    return val;
  endfunction

  // ********************
  // updates
  // ********************
  always_ff @(posedge clk) begin
    if (!rstN) begin
      readyBits <= '0;
    end else if (flush) begin
      readyBits <= '0;                    // mispredict drops every result.
    end else begin
      if (cdbValid)
        readyBits[cdbTag] <= 1'b1;
      if (commitValid)
        readyBits[commitTag] <= 1'b0;     // entry free for reuse.
    end
  end

  always_ff @(posedge clk) begin
    if (cdbValid && !flush)
      resultMem[cdbTag] <= cdbValue;
  end

  // ********************
  // read ports
  // ********************
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rd1Ready <= 1'b0;
      rd2Ready <= 1'b0;
    end else begin
      rd1Ready <= fwdReady(rd1Tag);
      rd2Ready <= fwdReady(rd2Tag);
    end
  end

  always_ff @(posedge clk) begin
    rd1Value <= fwdValue(rd1Tag);         // only meaningful with ready.
    rd2Value <= fwdValue(rd2Tag);
  end

endmodule

// ==== hw/archRegState.sv ====
`timescale 1ns/1ps
`include "renameStage_config.svh"

module archRegState import renamePkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  archRegT rd1Reg,      // source lookups.
  input  archRegT rd2Reg,
  input  logic    renValid,    // destination rename.
  input  archRegT renReg,
  input  robTagT  renTag,
  input  logic    commitValid, // retiring result.
  input  archRegT commitReg,
  input  robTagT  commitTag,
  input  dataT    commitValue,
  input  logic    flush,
  output logic    rd1Busy,
  output robTagT  rd1Tag,
  output dataT    rd1Value,
  output logic    rd2Busy,
  output robTagT  rd2Tag,
  output dataT    rd2Value,
  output robTagT  rd1NextTag,  // alias before this edge, for the ROB lookup.
  output robTagT  rd2NextTag
);

  // ********************
  // storage
  // ********************
  dataT                         regValue [`RENAME_REG_COUNT]; // committed values.
  robTagT                       aliasTag [`RENAME_REG_COUNT]; // youngest writer.
  logic [`RENAME_REG_COUNT-1:0] busyBits;                     // writer in flight.

  // busy bit seen by a read on this edge, before the rename.
  function automatic logic fwdBusy(archRegT r);
    logic bsy;
    bsy = busyBits[r];
    if (commitValid && commitReg == r && aliasTag[r] == commitTag)
      bsy = 1'b0;                         // its last writer retires now.
    if (flush)
      bsy = 1'b0;
    return bsy;
  endfunction

  function automatic dataT fwdValue(archRegT r);
    dataT val;
    val = regValue[r];
    if (commitValid && !flush && commitReg == r)
      val = commitValue;
    return val;
  endfunction

  assign rd1NextTag = aliasTag[rd1Reg];
  assign rd2NextTag = aliasTag[rd2Reg];

  // ********************
  // updates
  // ********************
  always_ff @(posedge clk) begin
    if (!rstN) begin
      busyBits <= '0;
      for (int i = 0; i < `RENAME_REG_COUNT; i++) begin
        regValue[i] <= '0;
        aliasTag[i] <= '0;
      end
    end else if (flush) begin
      busyBits <= '0;                     // values stay, aliases go stale.
    end else begin
      if (commitValid) begin
        regValue[commitReg] <= commitValue;
        if (aliasTag[commitReg] == commitTag)
          busyBits[commitReg] <= 1'b0;    // no newer writer.
      end
      if (renValid) begin                 // rename wins over commit clear.
        busyBits[renReg] <= 1'b1;
        aliasTag[renReg] <= renTag;
      end
    end
  end

  // ********************
  // read ports
  // ********************
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rd1Busy <= 1'b0;
      rd2Busy <= 1'b0;
      rd1Tag  <= '0;
      rd2Tag  <= '0;
    end else begin
      rd1Busy <= fwdBusy(rd1Reg);
      rd2Busy <= fwdBusy(rd2Reg);
      rd1Tag  <= rd1NextTag;              // pre-rename mapping.
      rd2Tag  <= rd2NextTag;
    end
  end

  always_ff @(posedge clk) begin
    rd1Value <= fwdValue(rd1Reg);
    rd2Value <= fwdValue(rd2Reg);
  end

endmodule

// ==== hw/operandSelect.sv ====
`timescale 1ns/1ps

module operandSelect import renamePkg::*; (
  // source 1 lookups.
  input  logic   regBusy1,
  input  robTagT regTag1,
  input  dataT   regValue1,
  input  logic   robReady1,
  input  dataT   robValue1,
  // source 2 lookups.
  input  logic   regBusy2,
  input  robTagT regTag2,
  input  dataT   regValue2,
  input  logic   robReady2,
  input  dataT   robValue2,
  // reservation station operands.
  output logic   op1Ready,
  output dataT   op1Value,
  output robTagT op1Tag,
  output logic   op2Ready,
  output dataT   op2Value,
  output robTagT op2Tag
);

  // ********************
  // per-source rule
  // ********************

  // committed, or finished but not yet retired.
  function automatic logic pickReady(logic busy, logic robRdy);
    logic rdy;
    rdy = !busy || robRdy;
    return rdy;
  endfunction

  // register file first, ROB second, else zero while waiting.
  function automatic dataT pickValue(logic busy, logic robRdy,
                                     dataT regVal, dataT robVal);
    dataT val;
    if (!busy)
      val = regVal;
    else if (robRdy)
      val = robVal;                       // result on its way to commit.
    else
      val = '0;
    return val;
  endfunction

  // ********************
  // source 1
  // ********************
  assign op1Ready = pickReady(regBusy1, robReady1);
  assign op1Value = pickValue(regBusy1, robReady1, regValue1, robValue1);
  assign op1Tag   = regTag1;              // alias always passed on.

  // ********************
  // source 2
  // ********************
  assign op2Ready = pickReady(regBusy2, robReady2);
  assign op2Value = pickValue(regBusy2, robReady2, regValue2, robValue2);
  assign op2Tag   = regTag2;

endmodule

// ==== hw/renameOperandStage.sv ====
`timescale 1ns/1ps

module renameOperandStage import renamePkg::*; (
  input  logic    clk,
  input  logic    rstN,
  // rename request.
  input  logic    reqValid,
  input  archRegT src1Reg,
  input  archRegT src2Reg,
  input  logic    dstValid,
  input  archRegT dstReg,
  input  robTagT  dstTag,
  // CDB broadcast.
  input  logic    cdbValid,
  input  robTagT  cdbTag,
  input  dataT    cdbValue,
  // commit.
  input  logic    commitValid,
  input  robTagT  commitTag,
  input  archRegT commitReg,
  input  dataT    commitValue,
  input  logic    flush,
  // operands, one cycle after the request.
  output logic    outValid,
  output logic    op1Ready,
  output dataT    op1Value,
  output robTagT  op1Tag,
  output logic    op2Ready,
  output dataT    op2Value,
  output robTagT  op2Tag
);

  logic   renValid;
  logic   regBusy1, regBusy2;
  robTagT regTag1, regTag2;
  dataT   regValue1, regValue2;
  robTagT nextTag1, nextTag2;             // unregistered alias, ROB address.
  logic   robReady1, robReady2;
  dataT   robValue1, robValue2;

  assign renValid = reqValid && dstValid;

  // request valid follows the registered lookups.
  always_ff @(posedge clk) begin
    if (!rstN || flush)
      outValid <= 1'b0;
    else
      outValid <= reqValid;
  end

  // ********************
  // lookups
  // ********************
  archRegState u_archRegState (
    .clk(clk), .rstN(rstN),
    .rd1Reg(src1Reg), .rd2Reg(src2Reg),
    .renValid(renValid), .renReg(dstReg), .renTag(dstTag),
    .commitValid(commitValid), .commitReg(commitReg),
    .commitTag(commitTag), .commitValue(commitValue),
    .flush(flush),
    .rd1Busy(regBusy1), .rd1Tag(regTag1), .rd1Value(regValue1),
    .rd2Busy(regBusy2), .rd2Tag(regTag2), .rd2Value(regValue2),
    .rd1NextTag(nextTag1), .rd2NextTag(nextTag2)
  );

  robValueBuffer u_robValueBuffer (
    .clk(clk), .rstN(rstN),
    .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbValue(cdbValue),
    .commitValid(commitValid), .commitTag(commitTag),
    .flush(flush),
    .rd1Tag(nextTag1), .rd2Tag(nextTag2),
    .rd1Ready(robReady1), .rd1Value(robValue1),
    .rd2Ready(robReady2), .rd2Value(robValue2)
  );

  // ********************
  // merge
  // ********************
  operandSelect u_operandSelect (
    .regBusy1(regBusy1), .regTag1(regTag1), .regValue1(regValue1),
    .robReady1(robReady1), .robValue1(robValue1),
    .regBusy2(regBusy2), .regTag2(regTag2), .regValue2(regValue2),
    .robReady2(robReady2), .robValue2(robValue2),
    .op1Ready(op1Ready), .op1Value(op1Value), .op1Tag(op1Tag),
    .op2Ready(op2Ready), .op2Value(op2Value), .op2Tag(op2Tag)
  );

endmodule

// ==== test/tbRenameStage.sv ====
`timescale 1ns/1ps

module tbRenameStage import renamePkg::*; ();

  localparam string TEST_FILE = "test/renameTests.txt";

  // one line of the test file.
  typedef struct packed {
    logic    reqValid;
    archRegT src1Reg;
    archRegT src2Reg;
    logic    dstValid;
    archRegT dstReg;
    robTagT  dstTag;
    logic    cdbValid;
    robTagT  cdbTag;
    dataT    cdbValue;
    logic    commitValid;
    robTagT  commitTag;
    archRegT commitReg;
    dataT    commitValue;
    logic    flush;
    logic    expValid;                    // operands of this line's request.
    logic    exp1Ready;
    dataT    exp1Value;
    robTagT  exp1Tag;
    logic    exp2Ready;
    dataT    exp2Value;
    robTagT  exp2Tag;
  } testRecT;

  logic    clk = 1'b0;
  logic    rstN;
  logic    reqValid, dstValid, cdbValid, commitValid, flush;
  archRegT src1Reg, src2Reg, dstReg, commitReg;
  robTagT  dstTag, cdbTag, commitTag;
  dataT    cdbValue, commitValue;
  logic    outValid, op1Ready, op2Ready;
  dataT    op1Value, op2Value;
  robTagT  op1Tag, op2Tag;

  testRecT tests [$];
  testRecT idleRec = '0;
  logic    loaded = 1'b0;
  int      seed = 32'h2777;              // idle cycle filler.

  renameOperandStage u_renameOperandStage (.*);

  always #5 clk = ~clk;                   // 10 ns period.

  // ********************
  // failure and compares
  // ********************
  task automatic failRun(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input dataT got, input dataT exp);
    if (got !== exp)
      failRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic checkTag(input string name, input robTagT got, input robTagT exp);
    if (got !== exp)
      failRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
      failRun($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  // operands are only compared for a request that survives.
  task automatic checkOperands(input testRecT rec, input int idx);
    checkFlag($sformatf("rec %0d outValid", idx), outValid, rec.expValid);
    if (rec.expValid) begin
      checkFlag($sformatf("rec %0d op1Ready", idx), op1Ready, rec.exp1Ready);
      checkValue($sformatf("rec %0d op1Value", idx), op1Value, rec.exp1Value);
      checkTag($sformatf("rec %0d op1Tag", idx), op1Tag, rec.exp1Tag);
      checkFlag($sformatf("rec %0d op2Ready", idx), op2Ready, rec.exp2Ready);
      checkValue($sformatf("rec %0d op2Value", idx), op2Value, rec.exp2Value);
      checkTag($sformatf("rec %0d op2Tag", idx), op2Tag, rec.exp2Tag);
    end
  endtask

  // ********************
  // stimulus
  // ********************
  task automatic loadTests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [21];
    testRecT     rec;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      failRun($sformatf("could not open the test file %s", TEST_FILE));
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.substr(0, 1) != "//") begin   // skip comments.
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                      f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
          if (n != 21) begin
            failRun($sformatf("test file line has %0d fields instead of 21", n));
          end else begin
            rec.reqValid    = f[0][0];
            rec.src1Reg     = archRegT'(f[1]);
            rec.src2Reg     = archRegT'(f[2]);
            rec.dstValid    = f[3][0];
            rec.dstReg      = archRegT'(f[4]);
            rec.dstTag      = robTagT'(f[5]);
            rec.cdbValid    = f[6][0];
            rec.cdbTag      = robTagT'(f[7]);
            rec.cdbValue    = dataT'(f[8]);
            rec.commitValid = f[9][0];
            rec.commitTag   = robTagT'(f[10]);
            rec.commitReg   = archRegT'(f[11]);
            rec.commitValue = dataT'(f[12]);
            rec.flush       = f[13][0];
            rec.expValid    = f[14][0];
            rec.exp1Ready   = f[15][0];
            rec.exp1Value   = dataT'(f[16]);
            rec.exp1Tag     = robTagT'(f[17]);
            rec.exp2Ready   = f[18][0];
            rec.exp2Value   = dataT'(f[19]);
            rec.exp2Tag     = robTagT'(f[20]);
            tests.push_back(rec);
          end
        end
      end
      $fclose(fd);
      loaded = 1'b1;
    end
  endtask

  // fields of an idle bus get random filler.
  task automatic driveRecord(input testRecT rec);
    reqValid    <= rec.reqValid;
    cdbValid    <= rec.cdbValid;
    commitValid <= rec.commitValid;
    flush       <= rec.flush;
    if (rec.reqValid) begin
      src1Reg  <= rec.src1Reg;
      src2Reg  <= rec.src2Reg;
      dstValid <= rec.dstValid;
    end else begin
      src1Reg  <= archRegT'($random(seed));
      src2Reg  <= archRegT'($random(seed));
      dstValid <= 1'($random(seed));      // gated by reqValid anyway.
    end
    if (rec.reqValid && rec.dstValid) begin
      dstReg <= rec.dstReg;
      dstTag <= rec.dstTag;
    end else begin
      dstReg <= archRegT'($random(seed));
      dstTag <= robTagT'($random(seed));
    end
    cdbTag      <= rec.cdbValid ? rec.cdbTag : robTagT'($random(seed));
    cdbValue    <= rec.cdbValid ? rec.cdbValue : dataT'($random(seed));
    commitTag   <= rec.commitValid ? rec.commitTag : robTagT'($random(seed));
    commitReg   <= rec.commitValid ? rec.commitReg : archRegT'($random(seed));
    commitValue <= rec.commitValid ? rec.commitValue : dataT'($random(seed));
  endtask

  // ********************
  // main sequence
  // ********************
  initial begin
    rstN <= 1'b0;
    driveRecord(idleRec);
    loadTests();
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkFlag("outValid after reset", outValid, 1'b0);
    // drive line i, then check line i-1 one edge later.
    for (int i = 0; i <= tests.size(); i++) begin
      @(posedge clk);
      if (i < tests.size())
        driveRecord(tests[i]);
      else
        driveRecord(idleRec);             // flush out the last request.
      @(negedge clk);                     // outputs settled here.
      if (i > 0)
        checkOperands(tests[i-1], i - 1);
    end
    $display("Finished with no errors");
    $finish;
  end

  // watchdog sized from the record count.
  initial begin
    wait (loaded);
    #((tests.size() + 10) * 10);
    failRun($sformatf("timeout, the run did not end within %0d cycles",
                      tests.size() + 10));
  end

endmodule

// ==== build.f ====
+incdir+hw
hw/renamePkg.sv
hw/robValueBuffer.sv
hw/archRegState.sv
hw/operandSelect.sv
hw/renameOperandStage.sv
test/tbRenameStage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rename operand stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tbRenameStage -f build.f -o simRename

# the run itself never stops the script, the log decides
./obj_dir/simRename 2>&1 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== test/renameTests.txt ====
// cols: reqValid src1 src2 dstValid dstReg dstTag | cdbValid cdbTag cdbValue |
//   commitValid commitTag commitReg commitValue | flush | expValid r1 v1 t1 r2 v2 t2
// reset state, idle then plain lookups.
0 0 0 0 0 0  0 0 00000000  0 0 0 00000000  0  0 0 00000000 0 0 00000000 0
1 1 2 0 0 0  0 0 00000000  0 0 0 00000000  0  1 1 00000000 0 1 00000000 0
// rename r5 and r7, then read them back.
1 3 4 1 5 1  0 0 00000000  0 0 0 00000000  0  1 1 00000000 0 1 00000000 0
1 5 6 1 7 2  0 0 00000000  0 0 0 00000000  0  1 0 00000000 1 1 00000000 0
// same-edge broadcast of tag 1.
1 7 5 0 0 0  1 1 1111aaaa  0 0 0 00000000  0  1 0 00000000 2 1 1111aaaa 1
1 5 0 0 0 0  0 0 00000000  0 0 0 00000000  0  1 1 1111aaaa 1 1 00000000 0
0 0 0 0 0 0  0 0 00000000  0 0 0 00000000  0  0 0 00000000 0 0 00000000 0
// same-edge commit of r5.
1 5 7 0 0 0  0 0 00000000  1 1 5 1111aaaa  0  1 1 1111aaaa 1 0 00000000 2
// r7 reads its own older mapping, then renamed again under tag 3.
1 7 8 1 7 3  0 0 00000000  0 0 0 00000000  0  1 0 00000000 2 1 00000000 0
0 0 0 0 0 0  1 2 22220002  0 0 0 00000000  0  0 0 00000000 0 0 00000000 0
// commit of the older tag 2 keeps r7 busy.
1 7 5 0 0 0  0 0 00000000  1 2 7 22220002  0  1 0 00000000 3 1 1111aaaa 1
// back to back chain on r9 and r3.
1 9 9 1 9 4  0 0 00000000  0 0 0 00000000  0  1 1 00000000 0 1 00000000 0
1 9 3 1 3 5  0 0 00000000  0 0 0 00000000  0  1 0 00000000 4 1 00000000 0
1 3 9 0 0 0  1 4 44440004  0 0 0 00000000  0  1 0 00000000 5 1 44440004 4
1 9 7 0 0 0  0 0 00000000  0 0 0 00000000  0  1 1 44440004 4 0 00000000 3
// flush with a request, its rename of r5 is dropped.
1 9 5 1 5 6  0 0 00000000  0 0 0 00000000  1  0 0 00000000 0 0 00000000 0
1 7 9 0 0 0  0 0 00000000  0 0 0 00000000  0  1 1 22220002 3 1 00000000 4
1 5 3 0 0 0  0 0 00000000  0 0 0 00000000  0  1 1 1111aaaa 1 1 00000000 5
// tag 4 reused, its ready bit went with the flush.
1 2 1 1 2 4  0 0 00000000  0 0 0 00000000  0  1 1 00000000 0 1 00000000 0
1 2 2 0 0 0  0 0 00000000  0 0 0 00000000  0  1 0 00000000 4 0 00000000 4
1 2 0 1 0 5  1 4 0badf00d  0 0 0 00000000  0  1 1 0badf00d 4 1 00000000 0
1 0 2 0 0 0  0 0 00000000  1 4 2 0badf00d  0  1 0 00000000 5 1 0badf00d 4
0 0 0 0 0 0  0 0 00000000  0 0 0 00000000  0  0 0 00000000 0 0 00000000 0
1 2 5 0 0 0  0 0 00000000  0 0 0 00000000  0  1 1 0badf00d 4 1 1111aaaa 1
// idle flush clears r0 busy.
0 0 0 0 0 0  0 0 00000000  0 0 0 00000000  1  0 0 00000000 0 0 00000000 0
1 0 7 0 0 0  0 0 00000000  0 0 0 00000000  0  1 1 00000000 5 1 22220002 3
0 0 0 0 0 0  0 0 00000000  0 0 0 00000000  0  0 0 00000000 0 0 00000000 0
